/* design/batch_if.sv */
// one batch per load pulse; payload words are only meaningful where valid is set
`timescale 1ns/1ps

interface batch_if;
    import hit_collector_pkg::*;

    logic                                  load;    // one-cycle batch strobe
    logic [NUM_LANES-1:0][PAYLOAD_W-1:0]   payload; // lane fifo heads
    logic [NUM_LANES-1:0]                  valid;   // lanes popped this batch
    logic                                  busy;    // serializer still streaming

    // gather side drives the batch, sees busy
    modport control (
        output load,
        output payload,
        output valid,
        input  busy
    );

    // serializer side samples the batch on load
    modport serializer (
        input  load,
        input  payload,
        input  valid,
        output busy
    );

endinterface

/* design/gather_ctrl.sv */
// batch start is combinational from lane and output state; needs NUM_LANES free output slots
`timescale 1ns/1ps

module gather_ctrl (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic [hit_collector_pkg::NUM_LANES-1:0]
                 [hit_collector_pkg::PAYLOAD_W-1:0]             head_i,   // lane heads
    input  logic [hit_collector_pkg::NUM_LANES-1:0]             empty_i,
    output logic [hit_collector_pkg::NUM_LANES-1:0]             pop_o,
    input  logic [hit_collector_pkg::NUM_LANES-1:0]             drop_i,   // lane overflow
    input  logic [hit_collector_pkg::OUT_CNT_W-1:0]             free_slots_i,
    input  logic [hit_collector_pkg::NUM_LANES-1:0]             clear_mask_i,
    output logic [hit_collector_pkg::NUM_LANES-1:0]             overflow_o,
    batch_if.control                                            batch
);
    import hit_collector_pkg::*;

    logic                 any_ready;    // at least one lane holds a word
    logic                 room_ok;      // output fifo can take a full batch
    logic                 start;        // take a batch this cycle
    logic [NUM_LANES-1:0] ready;
    logic [NUM_LANES-1:0] overflow_q;

    assign ready     = ~empty_i;
    assign any_ready = |ready;
    assign room_ok   = (free_slots_i >= OUT_CNT_W'(NUM_LANES)); // worst case batch
    assign start     = any_ready && room_ok && !batch.busy;

    // pops and load share the same cycle
    assign pop_o         = start ? ready : '0;
    assign batch.load    = start;
    assign batch.valid   = start ? ready : '0;
    assign batch.payload = head_i;                       // sampled by serializer on load

    // sticky flags; a drop wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow_q <= '0;
        end else begin
            overflow_q <= (overflow_q & ~clear_mask_i) | drop_i;
        end
    end

    assign overflow_o = overflow_q;

    // busy must rise on the edge after a load so the held batch is never overwritten
    a_load_starts : assert property (
        @(posedge clk) disable iff (reset)
        batch.load && (|batch.valid) |=> batch.busy
    ) else $error("gather_ctrl: serializer did not start on load");

endmodule

/* design/hit_collector.sv */
// lanes packed low to high in lane_data_i; wishbone classic, 32-bit single accesses only
`timescale 1ns/1ps

module hit_collector (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [hit_collector_pkg::NUM_LANES-1:0]     lane_valid_i,
    input  logic [hit_collector_pkg::NUM_LANES*hit_collector_pkg::PAYLOAD_W-1:0]
                                                        lane_data_i,  // lane 0 at lsb
    input  logic                                        wb_cyc_i,
    input  logic                                        wb_stb_i,
    input  logic                                        wb_we_i,
    input  logic [3:2]                                  wb_adr_i,
    input  logic [hit_collector_pkg::WORD_W-1:0]        wb_dat_i,
    output logic [hit_collector_pkg::WORD_W-1:0]        wb_dat_o,
    output logic                                        wb_ack_o
);
    import hit_collector_pkg::*;

    logic [NUM_LANES-1:0][PAYLOAD_W-1:0] head;        // lane fifo heads
    logic [NUM_LANES-1:0]                empty;
    logic [NUM_LANES-1:0]                pop;
    logic [NUM_LANES-1:0]                drop;
    logic [NUM_LANES-1:0]                overflow;
    logic [NUM_LANES-1:0]                clear_mask;
    logic [OUT_CNT_W-1:0]                free_slots;
    logic [WORD_W-1:0]                   word;        // serial stream
    logic                                word_valid;

    batch_if i_batch ();

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        lane_fifo i_lane_fifo (
            .clk     (clk),
            .reset   (reset),
            .push_i  (lane_valid_i[g]),
            .data_i  (lane_data_i[g*PAYLOAD_W +: PAYLOAD_W]),
            .pop_i   (pop[g]),
            .data_o  (head[g]),
            .empty_o (empty[g]),
            .full_o  (),                               // drop_o already covers full
            .drop_o  (drop[g])
        );
    end

    gather_ctrl i_gather_ctrl (
        .clk          (clk),
        .reset        (reset),
        .head_i       (head),
        .empty_i      (empty),
        .pop_o        (pop),
        .drop_i       (drop),
        .free_slots_i (free_slots),
        .clear_mask_i (clear_mask),
        .overflow_o   (overflow),
        .batch        (i_batch.control)
    );

    word_serializer i_word_serializer (
        .clk          (clk),
        .reset        (reset),
        .batch        (i_batch.serializer),
        .word_o       (word),
        .word_valid_o (word_valid)
    );

    wb_readout i_wb_readout (
        .clk          (clk),
        .reset        (reset),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .word_i       (word),
        .word_valid_i (word_valid),
        .overflow_i   (overflow),
        .free_slots_o (free_slots),
        .clear_mask_o (clear_mask)
    );

endmodule

/* design/hit_collector_pkg.sv */
// shared sizes and register map; tag split assumes at most 8 lanes and 32-bit words only
package hit_collector_pkg;

    // lanes and sample words
    localparam int NUM_LANES  = 5;            // front-end input lanes
    localparam int LANE_BITS  = 3;            // lane tag width, also batch count width
    localparam int PAYLOAD_W  = 29;           // raw sample width
    localparam int WORD_W     = 32;           // tag in 31..29, payload in 28..0

    // per-lane buffering
    localparam int LANE_DEPTH = 4;            // entries per lane fifo
    localparam int LANE_PTR_W = 2;            // wraps naturally at depth 4
    localparam int LANE_CNT_W = 3;            // holds 0..LANE_DEPTH

    // output buffering toward the host
    localparam int OUT_DEPTH  = 16;           // entries in readout fifo
    localparam int OUT_PTR_W  = 4;            // wraps naturally at depth 16
    localparam int OUT_CNT_W  = 5;            // holds 0..OUT_DEPTH

    // wishbone word addresses, taken from adr[3:2]
    localparam logic [1:0] ADDR_STATUS = 2'd0; // fill count + overflow flags
    localparam logic [1:0] ADDR_DATA   = 2'd1; // pop-on-read data port

    // status register layout
    // bits 4..0 carry the fill count, bits 12..8 the sticky lane flags
    localparam int STAT_FLAG_LSB = 8;         // first overflow flag bit

endpackage

/* design/lane_fifo.sv */
// depth fixed by LANE_DEPTH (power of two); head is zero while empty, full push drops the word
`timescale 1ns/1ps

module lane_fifo (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    push_i,  // sample strobe
    input  logic [hit_collector_pkg::PAYLOAD_W-1:0] data_i,
    input  logic                                    pop_i,   // from gather_ctrl
    output logic [hit_collector_pkg::PAYLOAD_W-1:0] data_o,  // head word
    output logic                                    empty_o,
    output logic                                    full_o,
    output logic                                    drop_o   // push lost, full
);
    import hit_collector_pkg::*;

    logic [PAYLOAD_W-1:0]  mem [LANE_DEPTH];   // storage, no reset
    logic [LANE_PTR_W-1:0] wr_ptr;
    logic [LANE_PTR_W-1:0] rd_ptr;
    logic [LANE_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign empty_o = (count == '0);
    assign full_o  = (count == LANE_CNT_W'(LANE_DEPTH));
    assign do_pop  = pop_i && !empty_o;                  // guard, pop on empty is ignored
    assign do_push = push_i && (!full_o || do_pop);      // full + pop still takes the word
    assign drop_o  = push_i && full_o && !do_pop;        // one pulse per lost word
    assign data_o  = empty_o ? '0 : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;                       // written on the strobe edge
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;                 // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                 // both or neither
            endcase
        end
    end

    // gather_ctrl must only pop lanes it saw as non-empty
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (reset)
        pop_i |-> !empty_o
    ) else $error("lane_fifo: pop while empty");

endmodule

/* design/wb_readout.sv */
// wishbone classic single access only; sel ignored, 32-bit words, data writes are ignored
`timescale 1ns/1ps

module wb_readout (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    wb_cyc_i,
    input  logic                                    wb_stb_i,
    input  logic                                    wb_we_i,
    input  logic [3:2]                              wb_adr_i,      // word address
    input  logic [hit_collector_pkg::WORD_W-1:0]    wb_dat_i,
    output logic [hit_collector_pkg::WORD_W-1:0]    wb_dat_o,
    output logic                                    wb_ack_o,
    input  logic [hit_collector_pkg::WORD_W-1:0]    word_i,        // serializer stream
    input  logic                                    word_valid_i,
    input  logic [hit_collector_pkg::NUM_LANES-1:0] overflow_i,    // sticky lane flags
    output logic [hit_collector_pkg::OUT_CNT_W-1:0] free_slots_o,
    output logic [hit_collector_pkg::NUM_LANES-1:0] clear_mask_o   // one-cycle pulse
);
    import hit_collector_pkg::*;

    logic [WORD_W-1:0]    mem [OUT_DEPTH];   // output fifo storage
    logic [OUT_PTR_W-1:0] wr_ptr;
    logic [OUT_PTR_W-1:0] rd_ptr;
    logic [OUT_CNT_W-1:0] count;
    logic                 empty;
    logic                 full;
    logic                 req;               // new access, ack not yet given
    logic                 pop;
    logic [WORD_W-1:0]    rd_word;
    logic                 ack_q;
    logic [WORD_W-1:0]    dat_q;
    logic [NUM_LANES-1:0] clear_q;

    assign empty        = (count == '0);
    assign full         = (count == OUT_CNT_W'(OUT_DEPTH));
    assign free_slots_o = OUT_CNT_W'(OUT_DEPTH) - count;
    assign req          = wb_cyc_i && wb_stb_i && !ack_q;
    assign pop          = req && !wb_we_i && (wb_adr_i == ADDR_DATA) && !empty;

    // register mux, sampled together with ack
    always_comb begin
        rd_word = '0;
        case (wb_adr_i)
            ADDR_STATUS: begin
                rd_word[OUT_CNT_W-1:0]               = count;
                rd_word[STAT_FLAG_LSB +: NUM_LANES]  = overflow_i;
            end
            ADDR_DATA: begin
                rd_word = empty ? '0 : mem[rd_ptr];  // zero when nothing buffered
            end
            default: begin
                rd_word = '0;                        // unmapped words read zero
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (word_valid_i) begin
            mem[wr_ptr] <= word_i;                   // free-slot rule keeps room
        end
        if (req) begin
            dat_q <= rd_word;                        // read data, no reset
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ack_q   <= 1'b0;
            clear_q <= '0;
        end else begin
            ack_q   <= req;                          // single-cycle ack
            clear_q <= '0;
            if (req && wb_we_i && (wb_adr_i == ADDR_STATUS)) begin
                clear_q <= wb_dat_i[STAT_FLAG_LSB +: NUM_LANES];
            end
            if (word_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;             // pop on the ack edge
            end
            case ({word_valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign wb_ack_o     = ack_q;
    assign wb_dat_o     = dat_q;
    assign clear_mask_o = clear_q;

    // gather_ctrl must hold batches until NUM_LANES slots are free
    a_no_push_full : assert property (
        @(posedge clk) disable iff (reset)
        word_valid_i |-> !full
    ) else $error("wb_readout: word pushed into full output fifo");

endmodule

/* design/word_serializer.sv */
// one batch at a time; a new load while busy is not supported and is caught upstream
`timescale 1ns/1ps

module word_serializer (
    input  logic                                 clk,
    input  logic                                 reset,
    batch_if.serializer                          batch,
    output logic [hit_collector_pkg::WORD_W-1:0] word_o,       // lane-tagged word
    output logic                                 word_valid_o
);
    import hit_collector_pkg::*;

    logic [NUM_LANES-1:0][WORD_W-1:0] pack_word;   // compacted view of the batch
    logic [LANE_BITS-1:0]             pack_cnt;    // valid entries in the batch
    logic [NUM_LANES-1:0][WORD_W-1:0] buf_q;       // captured batch
    logic [LANE_BITS-1:0]             cnt_q;       // words to emit
    logic [LANE_BITS-1:0]             rd_cnt;      // next word to emit
    logic                             busy_q;

    // squeeze valid lanes to the front in ascending lane order
    always_comb begin : compact
        logic [LANE_BITS-1:0] n;
        n         = '0;
        pack_word = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (batch.valid[i]) begin
                pack_word[n] = {LANE_BITS'(i), batch.payload[i]}; // tag on top
                n            = n + 1'b1;
            end
        end
        pack_cnt = n;
    end

    always_ff @(posedge clk) begin
        if (batch.load) begin
            buf_q <= pack_word;                          // tagged words
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            rd_cnt <= '0;
        end else if (batch.load) begin
            busy_q <= (pack_cnt != '0);                  // empty batch emits nothing
            cnt_q  <= pack_cnt;
            rd_cnt <= '0;
        end else if (busy_q) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == cnt_q - 1'b1) begin
                busy_q <= 1'b0;                          // last word goes out this cycle
            end
        end
    end

    assign batch.busy   = busy_q;
    assign word_valid_o = busy_q;                        // quiet during the load cycle
    assign word_o       = buf_q[rd_cnt];                 // only meaningful while valid

    // every emitted word traces back to a load or an ongoing stream
    a_word_after_load : assert property (
        @(posedge clk) disable iff (reset)
        word_valid_o |-> $past(batch.load || batch.busy)
    ) else $error("word_serializer: word without preceding load");

endmodule

/* dv/hit_collector_tb.sv */
// single wishbone master; lanes fed slowly outside the overflow test keep the model exact
`timescale 1ns/1ps

module hit_collector_tb;
    import hit_collector_pkg::*;

    localparam int CYCLE_LIMIT = 6000;                       // about twice the summed test length
    localparam int STALL_FILL  = OUT_DEPTH - NUM_LANES + 1;  // output level that holds batches back

    logic                           clk;
    logic                           reset;
    logic [NUM_LANES-1:0]           lane_valid_i;
    logic [NUM_LANES*PAYLOAD_W-1:0] lane_data_i;             // lane 0 at lsb
    logic                           wb_cyc_i;
    logic                           wb_stb_i;
    logic                           wb_we_i;
    logic [3:2]                     wb_adr_i;
    logic [WORD_W-1:0]              wb_dat_i;
    logic [WORD_W-1:0]              wb_dat_o;
    logic                           wb_ack_o;

    logic [PAYLOAD_W-1:0] lane_q [NUM_LANES][$];             // accepted words in arrival order
    int                   lane_cnt [NUM_LANES];              // lane fill while batches are held
    logic                 blocked;                           // output held at STALL_FILL
    logic [31:0]          rng = 32'he1aa6093;
    int                   accepted_total = 0;
    int                   read_total = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   ack_cnt = 0;
    int                   ack_errors = 0;
    int                   cycle_cnt = 0;

    hit_collector i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                              // 40 ns period
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                                  // drive point after the edge
    endtask

    task automatic expect_equal(input string name, input logic [WORD_W-1:0] got,
                                input logic [WORD_W-1:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int nerr);
        if (nerr == 0) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: FAILED with %0d errors", num, name, nerr);
    endtask

    // one classic single access that returns on the ack cycle
    task automatic wb_access(input logic we, input logic [1:0] adr,
                             input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        next_cycle();
        while (!wb_ack_o) next_cycle();                      // watchdog bounds this wait
        rdata    = wb_dat_o;
        ack_cnt++;
        wb_cyc_i = 1'b0;                                     // stb dropped after ack
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // one strobe cycle on the lanes in mask with fresh payload on every lane
    task automatic push_lanes(input logic [NUM_LANES-1:0] mask);
        logic [31:0] r;
        for (int l = 0; l < NUM_LANES; l++) begin
            roll(r);
            lane_data_i[l*PAYLOAD_W +: PAYLOAD_W] = r[PAYLOAD_W-1:0];
            if (mask[l] && (!blocked || lane_cnt[l] < LANE_DEPTH)) begin
                lane_q[l].push_back(r[PAYLOAD_W-1:0]);       // accepted unless the lane is full
                accepted_total++;
                if (blocked) lane_cnt[l]++;
            end
        end
        lane_valid_i = mask;
        next_cycle();
        lane_valid_i = '0;
    endtask

    task automatic read_and_check();
        logic [WORD_W-1:0] d;
        int                lane;
        wb_access(1'b0, ADDR_DATA, '0, d);
        lane = d[WORD_W-1 -: LANE_BITS];                     // tag in the top bits
        read_total++;
        expect_true(lane < NUM_LANES && lane_q[lane].size() > 0,
                    $sformatf("read word %h carries lane %0d with no word expected", d, lane));
        if (lane < NUM_LANES && lane_q[lane].size() > 0) begin
            expect_equal("wb_dat_o", d, {LANE_BITS'(lane), lane_q[lane].pop_front()});
        end
    endtask

    // poll status until the fill count reaches target
    task automatic wait_count(input int target);
        logic [WORD_W-1:0] d;
        int                polls;
        d     = '0;
        polls = 0;
        while (d[OUT_CNT_W-1:0] != OUT_CNT_W'(target) && polls < 40) begin
            wb_access(1'b0, ADDR_STATUS, '0, d);
            polls++;
        end
        expect_equal("status count", WORD_W'(d[OUT_CNT_W-1:0]), WORD_W'(target));
    endtask

    task automatic drain_all();
        logic [WORD_W-1:0] d;
        int                polls;
        polls = 0;
        while (read_total < accepted_total && polls < 200) begin
            wb_access(1'b0, ADDR_STATUS, '0, d);
            if (d[OUT_CNT_W-1:0] != '0) read_and_check();
            else next_cycle();
            polls++;
        end
        expect_true(read_total == accepted_total,
                    $sformatf("read %0d words but %0d were accepted", read_total, accepted_total));
        for (int l = 0; l < NUM_LANES; l++) begin
            expect_true(lane_q[l].size() == 0, $sformatf("lane %0d words never read back", l));
        end
    endtask

    initial begin
        logic [WORD_W-1:0] d;
        logic [31:0]       r;
        int                err_before;
        reset        = 1'b1;
        lane_valid_i = '0;
        lane_data_i  = '0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        blocked      = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) lane_cnt[l] = 0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        err_before = errors;                                 // idle bus and empty collector
        repeat (4) begin
            next_cycle();
            expect_equal("wb_ack_o", WORD_W'(wb_ack_o), '0);
        end
        wb_access(1'b0, ADDR_STATUS, '0, d);
        expect_equal("status", d, '0);
        wb_access(1'b0, ADDR_DATA, '0, d);
        expect_equal("wb_dat_o", d, '0);                     // empty read gives zero
        report_test(1, "idle after reset", errors - err_before);

        err_before = errors;
        push_lanes(5'b01000);                                // lane 3 only
        wait_count(1);
        read_and_check();
        report_test(2, "single word readout", errors - err_before);

        err_before = errors;
        repeat (3) begin
            push_lanes('1);                                  // all lanes together
            repeat (7) next_cycle();
        end
        wait_count(3 * NUM_LANES);
        drain_all();
        report_test(3, "all lanes tags and order", errors - err_before);

        err_before = errors;
        repeat (STALL_FILL) begin                            // fill output until batches hold
            push_lanes(5'b00001);
            repeat (7) next_cycle();
        end
        wait_count(STALL_FILL);
        blocked = 1'b1;
        repeat (LANE_DEPTH + 2) push_lanes(5'b00100);        // last two are dropped
        wb_access(1'b0, ADDR_STATUS, '0, d);
        expect_equal("status", d, WORD_W'(STALL_FILL) | (WORD_W'(1) << (STAT_FLAG_LSB + 2)));
        wb_access(1'b1, ADDR_STATUS, WORD_W'({NUM_LANES{1'b1}}) << STAT_FLAG_LSB, d);
        next_cycle();                                        // clear pulse reaches the flags
        wb_access(1'b0, ADDR_STATUS, '0, d);
        expect_equal("status", d, WORD_W'(STALL_FILL));
        blocked = 1'b0;
        drain_all();
        report_test(4, "lane overflow and clear", errors - err_before);

        err_before = errors;
        for (int it = 0; it < 200; it++) begin
            roll(r);
            push_lanes((accepted_total - read_total <= 9) ? r[NUM_LANES-1:0] : '0);
            repeat (5) next_cycle();                         // keeps lanes below depth
            if (r[8]) begin
                wb_access(1'b0, ADDR_STATUS, '0, d);
                if (d[OUT_CNT_W-1:0] != '0) read_and_check();
            end
            repeat (r[11:9]) next_cycle();                   // random host gap
        end
        drain_all();
        wb_access(1'b0, ADDR_STATUS, '0, d);
        expect_equal("status", d, '0);                       // no flags and nothing left
        report_test(5, "random run", errors - err_before);

        expect_true(ack_cnt > 0, "no wishbone ack seen during the run");
        report_test(6, $sformatf("ack timing over %0d acks", ack_cnt), ack_errors);

        $display("summary: 6 tests, %0d checks, %0d acks, %0d errors", checks, ack_cnt, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    a_ack_single : assert property (@(posedge clk) disable iff (reset)
        wb_ack_o |=> !wb_ack_o)
        else begin
            $display("wb_ack_o stayed high for more than one cycle");
            errors++;
            ack_errors++;
        end

    a_ack_after_stb : assert property (@(posedge clk) disable iff (reset)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i && !wb_ack_o))
        else begin
            $display("wb_ack_o rose without a strobe on the previous cycle");
            errors++;
            ack_errors++;
        end

    a_ack_on_time : assert property (@(posedge clk) disable iff (reset)
        wb_cyc_i && wb_stb_i && !wb_ack_o |=> wb_ack_o)
        else begin
            $display("wb_ack_o did not rise one cycle after the strobe");
            errors++;
            ack_errors++;
        end

    a_count_bound : assert property (@(posedge clk) disable iff (reset)
        (wb_ack_o && !$past(wb_we_i) && $past(wb_adr_i) == ADDR_STATUS)
            |-> wb_dat_o[OUT_CNT_W-1:0] <= OUT_CNT_W'(OUT_DEPTH))
        else begin
            $display("CHECK FAILED wb_dat_o count %h above OUT_DEPTH %h",
                     wb_dat_o[OUT_CNT_W-1:0], OUT_DEPTH);
            errors++;
        end

endmodule

/* hit_collector.f */
design/hit_collector_pkg.sv
design/batch_if.sv
design/lane_fifo.sv
design/word_serializer.sv
design/gather_ctrl.sv
design/wb_readout.sv
design/hit_collector.sv
dv/hit_collector_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the hit collector testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hit_collector_tb -f hit_collector.f

out=$(./obj_dir/Vhit_collector_tb)
echo "$out"

if grep -q "Testbench passed" <<< "$out"; then
    exit 0
fi
exit 1
